// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ======================================================================
    // Widths and reset values
    // ======================================================================

    // Address width of the core
    localparam int XLEN = 32;

    // One instruction address, byte addressed, word aligned
    typedef logic [XLEN-1:0] pc_t;

    // Fetch address after reset
    localparam pc_t RESET_PC = 32'h0000_0000;

    // Two-bit saturating direction counter
    typedef logic [1:0] ctr_t;

    // Weakly not-taken
    localparam ctr_t CTR_INIT = 2'b01;

    // ======================================================================
    // Records carried between fetch and execute
    // ======================================================================

    // Prediction made at fetch for the current pc
    typedef struct packed {
        logic hit;      // BTB tag matched a valid entry
        logic taken;    // Upper bit of the BHT counter
        pc_t  target;   // BTB target
    } pred_t;

    // Execute-stage outcome of one instruction
    typedef struct packed {
        logic  valid;
        logic  is_branch;
        logic  is_jump;
        // Comparator result, only meaningful for branches
        logic  cond_taken;
        pc_t   pc;
        // Computed target, present even when not taken
        pc_t   target;
        // Prediction issued when this pc was fetched
        pred_t pred;
    } resolve_t;

endpackage : fetch_pkg

`default_nettype wire

// File: src/btb.sv
`timescale 1ns/1ns
`default_nettype none

module btb #(
    parameter int INDEX_W = 8
) (
    input  logic           i_clk,
    input  logic           i_reset,
    // Lookup port
    input  fetch_pkg::pc_t i_pc,
    output logic           o_hit,
    output fetch_pkg::pc_t o_target,
    // Update port from execute
    input  logic           i_update_en,
    input  fetch_pkg::pc_t i_update_pc,
    input  fetch_pkg::pc_t i_update_target
);

    import fetch_pkg::*;

    localparam int ENTRIES = 1 << INDEX_W;
    localparam int TAG_W   = XLEN - INDEX_W - 2;

    // Tag and target stored per index
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        pc_t              target;
    } entry_t;

    logic [ENTRIES-1:0] valid_q;
    entry_t             entry_q [ENTRIES];

    logic [INDEX_W-1:0] rd_index;
    logic [TAG_W-1:0]   rd_tag;
    entry_t             rd_entry;
    logic [INDEX_W-1:0] wr_index;
    entry_t             wr_entry;

    // ======================================================================
    // Lookup
    // ======================================================================

    assign rd_index = i_pc[INDEX_W+1:2];
    assign rd_tag   = i_pc[XLEN-1:INDEX_W+2];
    assign rd_entry = entry_q[rd_index];

    assign o_hit    = valid_q[rd_index] && (rd_entry.tag == rd_tag);
    assign o_target = rd_entry.target;

    // ======================================================================
    // Update
    // ======================================================================

    assign wr_index = i_update_pc[INDEX_W+1:2];

    always_comb begin
        wr_entry.tag    = i_update_pc[XLEN-1:INDEX_W+2];
        wr_entry.target = i_update_target;
    end

    // Only the valid bits are cleared
    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            valid_q <= '0;
        end else if (i_update_en) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_update_en) begin
            entry_q[wr_index] <= wr_entry;
        end
    end

endmodule : btb

`default_nettype wire

// File: src/bht.sv
`timescale 1ns/1ns
`default_nettype none

module bht #(
    parameter int INDEX_W = 8
) (
    input  logic           i_clk,
    input  logic           i_reset,
    // Lookup port
    input  fetch_pkg::pc_t i_pc,
    output logic           o_pred_taken,
    // Update port from execute
    input  logic           i_update_en,
    input  fetch_pkg::pc_t i_update_pc,
    input  logic           i_actual_taken
);

    import fetch_pkg::*;

    localparam int   ENTRIES = 1 << INDEX_W;
    localparam ctr_t CTR_MIN = 2'b00;
    localparam ctr_t CTR_MAX = 2'b11;

    ctr_t               ctr_q [ENTRIES];

    logic [INDEX_W-1:0] rd_index;
    ctr_t               rd_ctr;
    logic [INDEX_W-1:0] wr_index;
    ctr_t               wr_ctr_cur;
    ctr_t               wr_ctr_next;

    // ======================================================================
    // Lookup
    // ======================================================================

    assign rd_index     = i_pc[INDEX_W+1:2];
    assign rd_ctr       = ctr_q[rd_index];
    // Predict taken in the two upper states
    assign o_pred_taken = rd_ctr[1];

    // ======================================================================
    // Update
    // ======================================================================

    assign wr_index   = i_update_pc[INDEX_W+1:2];
    assign wr_ctr_cur = ctr_q[wr_index];

    // Step toward the actual outcome, saturating at both ends
    always_comb begin
        wr_ctr_next = wr_ctr_cur;
        if (i_actual_taken) begin
            if (wr_ctr_cur != CTR_MAX) begin
                wr_ctr_next = wr_ctr_cur + 2'b01;
            end
        end else if (wr_ctr_cur != CTR_MIN) begin
            wr_ctr_next = wr_ctr_cur - 2'b01;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (i_update_en) begin
            ctr_q[wr_index] <= wr_ctr_next;
        end
    end

endmodule : bht

`default_nettype wire

// File: src/branch_resolver.sv
`timescale 1ns/1ns
`default_nettype none

module branch_resolver (
    input  fetch_pkg::resolve_t i_resolve,
    // Table update
    output logic                o_update_en,
    output logic                o_actual_taken,
    // Misprediction and redirect
    output logic                o_mispred,
    output fetch_pkg::pc_t      o_redirect_pc
);

    import fetch_pkg::*;

    logic actual_taken;
    logic pred_hit_taken;
    logic target_differs;
    logic wrong_taken;
    logic wrong_target;
    logic wrong_not_taken;
    pc_t  fall_through;

    // ======================================================================
    // Actual outcome
    // ======================================================================

    assign actual_taken = i_resolve.is_jump | (i_resolve.is_branch & i_resolve.cond_taken);

    // Only control-transfer instructions train the tables
    assign o_update_en    = i_resolve.valid & (i_resolve.is_branch | i_resolve.is_jump);
    assign o_actual_taken = actual_taken;

    // ======================================================================
    // Misprediction
    // ======================================================================

    assign pred_hit_taken = i_resolve.pred.hit & i_resolve.pred.taken;
    assign target_differs = (i_resolve.target != i_resolve.pred.target);

    // Predicted taken, fell through
    assign wrong_taken     = pred_hit_taken & ~actual_taken;
    // Predicted taken, went somewhere else
    assign wrong_target    = pred_hit_taken & actual_taken & target_differs;
    // Fetch went on to pc + 4 but the instruction jumped
    assign wrong_not_taken = ~pred_hit_taken & actual_taken;

    assign o_mispred = i_resolve.valid & (wrong_taken | wrong_target | wrong_not_taken);

    // ======================================================================
    // Redirect address
    // ======================================================================

    assign fall_through  = i_resolve.pc + pc_t'(4);
    assign o_redirect_pc = actual_taken ? i_resolve.target : fall_through;

endmodule : branch_resolver

`default_nettype wire

// File: src/pc_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module pc_sequencer #(
    parameter fetch_pkg::pc_t P_RESET_PC = fetch_pkg::RESET_PC
) (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_stall,
    // Prediction for the current pc
    input  fetch_pkg::pred_t i_pred,
    // Correction from execute
    input  logic             i_redirect,
    input  fetch_pkg::pc_t   i_redirect_pc,
    output fetch_pkg::pc_t   o_pc
);

    import fetch_pkg::*;

    pc_t pc_q;
    pc_t pc_plus4;
    pc_t pc_next;

    assign pc_plus4 = pc_q + pc_t'(4);

    // ======================================================================
    // Next-PC selection
    // ======================================================================

    // Redirect wins over stall, so a resolve is never held back
    always_comb begin
        if (i_redirect) begin
            pc_next = i_redirect_pc;
        end else if (i_stall) begin
            pc_next = pc_q;
        end else if (i_pred.hit && i_pred.taken) begin
            pc_next = i_pred.target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // ======================================================================
    // PC register
    // ======================================================================

    always_ff @(posedge i_clk) begin
        if (!i_reset) begin
            pc_q <= P_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign o_pc = pc_q;

endmodule : pc_sequencer

`default_nettype wire

// File: src/fetch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_predictor #(
    parameter int             INDEX_W    = 8,
    parameter fetch_pkg::pc_t P_RESET_PC = fetch_pkg::RESET_PC
) (
    input  logic                i_clk,
    input  logic                i_reset,
    // Fetch control
    input  logic                i_stall,
    // Outcome returned from execute
    input  fetch_pkg::resolve_t i_resolve,
    // Fetch address and its prediction
    output fetch_pkg::pc_t      o_pc,
    output fetch_pkg::pred_t    o_pred,
    output logic                o_mispred
);

    import fetch_pkg::*;

    // Fetch side
    pc_t   fetch_pc;
    logic  btb_hit;
    pc_t   btb_target;
    logic  bht_taken;
    pred_t fetch_pred;

    // Execute side
    logic  update_en;
    logic  actual_taken;
    logic  mispred;
    pc_t   redirect_pc;

    // ======================================================================
    // Program counter
    // ======================================================================

    pc_sequencer #(
        .P_RESET_PC   (P_RESET_PC)
    ) u_pc_sequencer (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_stall      (i_stall),
        .i_pred       (fetch_pred),
        .i_redirect   (mispred),
        .i_redirect_pc(redirect_pc),
        .o_pc         (fetch_pc)
    );

    // ======================================================================
    // Prediction tables
    // ======================================================================

    btb #(
        .INDEX_W        (INDEX_W)
    ) u_btb (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_pc           (fetch_pc),
        .o_hit          (btb_hit),
        .o_target       (btb_target),
        .i_update_en    (update_en),
        .i_update_pc    (i_resolve.pc),
        .i_update_target(i_resolve.target)
    );

    bht #(
        .INDEX_W       (INDEX_W)
    ) u_bht (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_pc          (fetch_pc),
        .o_pred_taken  (bht_taken),
        .i_update_en   (update_en),
        .i_update_pc   (i_resolve.pc),
        .i_actual_taken(actual_taken)
    );

    assign fetch_pred = '{hit: btb_hit, taken: bht_taken, target: btb_target};

    // ======================================================================
    // Resolution
    // ======================================================================

    branch_resolver u_branch_resolver (
        .i_resolve     (i_resolve),
        .o_update_en   (update_en),
        .o_actual_taken(actual_taken),
        .o_mispred     (mispred),
        .o_redirect_pc (redirect_pc)
    );

    assign o_pc      = fetch_pc;
    assign o_pred    = fetch_pred;
    assign o_mispred = mispred;

endmodule : fetch_predictor

`default_nettype wire

// File: verification/fetch_predictor_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_predictor_checker (
    input logic           i_clk,
    input logic           i_reset,
    input logic           i_stall,
    input logic           i_redirect,
    input fetch_pkg::pc_t i_redirect_pc,
    input fetch_pkg::pc_t i_pc
);

    // ======================================================================
    // PC sequencing properties
    // ======================================================================

    // Execute correction lands on the next fetch address
    redirect_lands : assert property (@(posedge i_clk) disable iff (!i_reset)
        i_redirect |=> (i_pc == $past(i_redirect_pc)))
        else $error("PC did not follow the redirect address");

    // Stall holds the fetch address
    stall_holds : assert property (@(posedge i_clk) disable iff (!i_reset)
        (i_stall && !i_redirect) |=> (i_pc == $past(i_pc)))
        else $error("PC moved during a stall");

    pc_aligned : assert property (@(posedge i_clk) disable iff (!i_reset)
        i_pc[1:0] == 2'b00)
        else $error("PC is not word aligned");

endmodule : fetch_predictor_checker

bind pc_sequencer fetch_predictor_checker u_checker (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_stall      (i_stall),
    .i_redirect   (i_redirect),
    .i_redirect_pc(i_redirect_pc),
    .i_pc         (o_pc)
);

`default_nettype wire

// File: verification/tb_fetch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_predictor;

    import fetch_pkg::*;

    localparam int  INDEX_W     = 8;
    localparam int  ENTRIES     = 1 << INDEX_W;
    localparam int  TAG_W       = XLEN - INDEX_W - 2;
    localparam int  RAND_CYCLES = 3000;
    localparam int  MAX_TIME_NS = 100000;
    // Jump used to bring fetch back to a trained address
    localparam pc_t VISIT_PC    = 32'h0000_0300;
    localparam pc_t SAT_PC      = 32'h0000_0060;

    logic     i_clk = 1'b0;
    logic     i_reset;
    logic     i_stall;
    resolve_t i_resolve;
    pc_t      o_pc;
    pred_t    o_pred;
    logic     o_mispred;

    // Reference model of both tables and the PC
    logic             m_valid  [ENTRIES];
    logic [TAG_W-1:0] m_tag    [ENTRIES];
    pc_t              m_target [ENTRIES];
    ctr_t             m_ctr    [ENTRIES];
    pc_t              m_pc;
    pred_t            seen_pred [16];
    int               seed;

    fetch_predictor #(
        .INDEX_W   (INDEX_W),
        .P_RESET_PC(RESET_PC)
    ) u_dut (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_stall  (i_stall),
        .i_resolve(i_resolve),
        .o_pc     (o_pc),
        .o_pred   (o_pred),
        .o_mispred(o_mispred)
    );

    always #5 i_clk = ~i_clk;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input pc_t actual, input pc_t expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Pairs of pool entries share an index with different tags
    function automatic pc_t pool_addr(input logic [3:0] sel);
        pc_t base;
        base = sel[3] ? 32'h0000_0400 : 32'h0000_0000;
        return base + 32'h0000_0040 + {25'b0, sel[2:0], 4'b0};
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic pred_t model_lookup(input pc_t pc);
        logic [INDEX_W-1:0] idx;
        pred_t              p;
        idx      = pc[INDEX_W+1:2];
        p.hit    = m_valid[idx] && (m_tag[idx] == pc[XLEN-1:INDEX_W+2]);
        p.taken  = m_ctr[idx][1];
        p.target = m_target[idx];
        return p;
    endfunction

    function automatic logic actual_outcome(input resolve_t res);
        return res.is_jump || (res.is_branch && res.cond_taken);
    endfunction

    function automatic logic expected_mispred(input resolve_t res);
        logic predicted;
        logic actual;
        predicted = res.pred.hit && res.pred.taken;
        actual    = actual_outcome(res);
        if (!res.valid)
            return 1'b0;
        if (predicted && !actual)
            return 1'b1;
        if (predicted && (res.target != res.pred.target))
            return 1'b1;
        return !predicted && actual;
    endfunction

    task automatic advance_model(input logic stall, input resolve_t res);
        pred_t              fp;
        logic [INDEX_W-1:0] idx;
        logic               actual;
        fp     = model_lookup(m_pc);
        actual = actual_outcome(res);
        if (expected_mispred(res))
            m_pc = actual ? res.target : res.pc + 32'd4;
        else if (!stall)
            m_pc = (fp.hit && fp.taken) ? fp.target : m_pc + 32'd4;
        if (res.valid && (res.is_branch || res.is_jump)) begin
            idx           = res.pc[INDEX_W+1:2];
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = res.pc[XLEN-1:INDEX_W+2];
            m_target[idx] = res.target;
            if (actual && (m_ctr[idx] != 2'b11))
                m_ctr[idx] = m_ctr[idx] + 2'b01;
            else if (!actual && (m_ctr[idx] != 2'b00))
                m_ctr[idx] = m_ctr[idx] - 2'b01;
        end
    endtask

    // ======================================================================
    // Stimulus and checks
    // ======================================================================

    task automatic check_fetch();
        pred_t expected_pred;
        expected_pred = model_lookup(m_pc);
        check_value(o_pc, m_pc, "fetch pc");
        check_value(pc_t'(o_pred.hit), pc_t'(expected_pred.hit), "prediction hit");
        check_value(pc_t'(o_pred.taken), pc_t'(expected_pred.taken), "prediction taken");
        if (m_valid[m_pc[INDEX_W+1:2]])
            check_value(o_pred.target, expected_pred.target, "prediction target");
        // Remember what fetch predicted, to echo it back at resolve
        for (int i = 0; i < 16; i++) begin
            if (m_pc == pool_addr(4'(i)))
                seen_pred[i] = expected_pred;
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic run_cycle(input logic stall, input resolve_t res);
        i_stall   = stall;
        i_resolve = res;
        #4;
        check_value(pc_t'(o_mispred), pc_t'(expected_mispred(res)), "mispredict strobe");
        advance_model(stall, res);
        @(posedge i_clk);
        #1;
        check_fetch();
    endtask

    task automatic random_resolve(output resolve_t res);
        int         r;
        logic [3:0] sel;
        r              = $random(seed);
        sel            = r[7:4];
        res.is_jump    = (r[1:0] == 2'd1);
        res.is_branch  = r[1];
        res.cond_taken = r[2];
        res.pc         = pool_addr(sel);
        res.target     = pool_addr(r[11:8]);
        res.pred       = seen_pred[sel];
        // Occasionally corrupt the echoed prediction
        case (r[14:12])
            3'd0: res.pred.hit = ~res.pred.hit;
            3'd1: res.pred.target = pool_addr(r[19:16]);
            3'd2: res.pred = '{hit: 1'b1, taken: ~res.pred.taken, target: res.pred.target};
            default: begin
            end
        endcase
        res.valid = ({$random(seed)} % 100) < 30;
    endtask

    task automatic train_branch(input pc_t addr, input logic taken);
        resolve_t res;
        res = '{valid: 1'b1, is_branch: 1'b1, is_jump: 1'b0, cond_taken: taken,
                pc: addr, target: pool_addr(4'd5), pred: model_lookup(addr)};
        run_cycle(1'b1, res);
    endtask

    // Redirect onto addr while stalled, then look at its prediction
    task automatic visit_and_check(input pc_t addr, input logic exp_taken);
        resolve_t res;
        res = '{valid: 1'b1, is_branch: 1'b0, is_jump: 1'b1, cond_taken: 1'b0,
                pc: VISIT_PC, target: addr, pred: '0};
        run_cycle(1'b1, res);
        check_value(o_pc, addr, "pc after redirect under stall");
        check_value(pc_t'(o_pred.hit), 32'd1, "trained entry hit");
        check_value(pc_t'(o_pred.taken), pc_t'(exp_taken), "counter direction");
    endtask

    initial begin
        resolve_t res;
        logic     stall;
        i_reset   = 1'b0;
        i_stall   = 1'b0;
        i_resolve = '0;
        seed      = 32'h5fa9;
        m_pc      = RESET_PC;
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_ctr[i]    = CTR_INIT;
        end
        for (int i = 0; i < 16; i++)
            seen_pred[i] = '0;

        repeat (10) @(posedge i_clk);
        #1;
        i_reset = 1'b1;
        check_fetch();
        check_value(o_pc, RESET_PC, "pc after reset");
        check_value(pc_t'(o_pred.hit), 32'd0, "hit after reset");
        check_value(pc_t'(o_mispred), 32'd0, "mispredict after reset");

        // Sequential fetch with stalls only
        for (int n = 0; n < 12; n++) begin
            stall = ({$random(seed)} % 100) < 20;
            run_cycle(stall, '0);
        end

        // Counter saturation on one address
        repeat (4) train_branch(SAT_PC, 1'b1);
        train_branch(SAT_PC, 1'b0);
        visit_and_check(SAT_PC, 1'b1);
        train_branch(SAT_PC, 1'b0);
        visit_and_check(SAT_PC, 1'b0);

        for (int n = 0; n < RAND_CYCLES; n++) begin
            stall = ({$random(seed)} % 100) < 20;
            random_resolve(res);
            run_cycle(stall, res);
        end

        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(MAX_TIME_NS);
        $display("Simulation ran past its time limit");
        abort_run();
    end

endmodule : tb_fetch_predictor

`default_nettype wire

// File: fetch_predictor.f
src/fetch_pkg.sv
src/btb.sv
src/bht.sv
src/branch_resolver.sv
src/pc_sequencer.sv
src/fetch_predictor.sv
verification/fetch_predictor_checker.sv
verification/tb_fetch_predictor.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_fetch_predictor
RTL_TOP   ?= fetch_predictor
FILELIST  ?= fetch_predictor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ns

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TB_TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
